//--- tb/l2_localmem_stim.txt
# W|w set way tag state hprot line (w shares the edge of the next record)
# F set mask state | E set evict_way | R set {line tag state hprot}x4 evict | T test
T 1
W 05 0 05a00 1 0 0500c0ffee
W 05 1 05a11 2 1 0501beef01
W 05 2 05a22 3 0 0502cafe02
W 05 3 05a33 4 1 0503f00d03
E 05 2
R 05 0500c0ffee 05a00 1 0 0501beef01 05a11 2 1 0502cafe02 05a22 3 0 0503f00d03 05a33 4 1 2
T 2
W 09 0 09b00 7 1 0900abcd10
W 09 1 09b11 0 0 0901abcd11
W 09 2 09b22 5 1 0902abcd12
W 09 3 09b33 6 0 0903abcd13
E 09 1
W 05 2 05d22 7 1 0502dead22
R 05 0500c0ffee 05a00 1 0 0501beef01 05a11 2 1 0502dead22 05d22 7 1 0503f00d03 05a33 4 1 2
R 09 0900abcd10 09b00 7 1 0901abcd11 09b11 0 0 0902abcd12 09b22 5 1 0903abcd13 09b33 6 0 1
T 3
F 09 a 2
R 09 0900abcd10 09b00 7 1 0901abcd11 09b11 2 0 0902abcd12 09b22 5 1 0903abcd13 09b33 2 0 1
w 05 0 05e00 3 1 0500e00e00
F 05 a 3
R 05 0500e00e00 05e00 3 1 0501beef01 05a11 3 1 0502dead22 05d22 7 1 0503f00d03 05a33 3 1 2
T 4
E 05 3
R 05 0500e00e00 05e00 3 1 0501beef01 05a11 3 1 0502dead22 05d22 7 1 0503f00d03 05a33 3 1 3
R 09 0900abcd10 09b00 7 1 0901abcd11 09b11 2 0 0902abcd12 09b22 5 1 0903abcd13 09b33 2 0 1
T 5
w 09 1 09f11 4 1 0901f00f11
R 09 0900abcd10 09b00 7 1 0901abcd11 09b11 2 0 0902abcd12 09b22 5 1 0903abcd13 09b33 2 0 1
R 09 0900abcd10 09b00 7 1 0901f00f11 09f11 4 1 0902abcd12 09b22 5 1 0903abcd13 09b33 2 0 1
T 6

//--- l2_localmem.f
rtl/l2_mem_pkg.sv
rtl/l2_wr_if.sv
rtl/l2_way_store.sv
rtl/l2_evict_store.sv
rtl/l2_localmem.sv
tb/l2_localmem_chk.sv
tb/tb_l2_localmem.sv

//--- Makefile
TOP = tb_l2_localmem

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f l2_localmem.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ]; then echo "simulator exited with status $$status"; exit 1; fi
	@if grep -q "Verification failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- tb/tb_l2_localmem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_l2_localmem;

    localparam int    reset_cycles    = 16;
    localparam int    cycles_per_line = 20;
    localparam string stim_path       = "tb/l2_localmem_stim.txt";

    logic                                          clk;
    logic                                          rst_n;
    l2_mem_pkg::set_t                              set_in;
    logic                                          rd_en;
    l2_mem_pkg::way_t                              way;
    logic                                          wr_en;
    l2_mem_pkg::line_t                             wr_data_line;
    l2_mem_pkg::tag_t                              wr_data_tag;
    l2_mem_pkg::state_t                            wr_data_state;
    l2_mem_pkg::hprot_t                            wr_data_hprot;
    l2_mem_pkg::way_mask_t                         wr_rst_flush;
    logic                                          wr_en_evict_way;
    l2_mem_pkg::way_t                              wr_data_evict_way;
    l2_mem_pkg::line_t  [l2_mem_pkg::num_ways-1:0] rd_data_line;
    l2_mem_pkg::tag_t   [l2_mem_pkg::num_ways-1:0] rd_data_tag;
    l2_mem_pkg::state_t [l2_mem_pkg::num_ways-1:0] rd_data_state;
    l2_mem_pkg::hprot_t [l2_mem_pkg::num_ways-1:0] rd_data_hprot;
    l2_mem_pkg::way_t                              rd_data_evict_way;

    // values collected from the stimulus file for the next driven edge
    l2_mem_pkg::set_t      nx_set;
    logic                  nx_rd;
    logic                  nx_wr;
    l2_mem_pkg::way_t      nx_way;
    l2_mem_pkg::line_t     nx_line;
    l2_mem_pkg::tag_t      nx_tag;
    l2_mem_pkg::state_t    nx_state;
    l2_mem_pkg::hprot_t    nx_hprot;
    l2_mem_pkg::way_mask_t nx_flush;
    logic                  nx_ev_en;
    l2_mem_pkg::way_t      nx_ev_way;

    int fd;
    int error_count;
    int tests_passed;
    int tests_failed;
    int watchdog_cycles;

    l2_localmem u_l2_localmem (
        .clk               (clk),
        .rst_n             (rst_n),
        .set_in            (set_in),
        .rd_en             (rd_en),
        .way               (way),
        .wr_en             (wr_en),
        .wr_data_line      (wr_data_line),
        .wr_data_tag       (wr_data_tag),
        .wr_data_state     (wr_data_state),
        .wr_data_hprot     (wr_data_hprot),
        .wr_rst_flush      (wr_rst_flush),
        .wr_en_evict_way   (wr_en_evict_way),
        .wr_data_evict_way (wr_data_evict_way),
        .rd_data_line      (rd_data_line),
        .rd_data_tag       (rd_data_tag),
        .rd_data_state     (rd_data_state),
        .rd_data_hprot     (rd_data_hprot),
        .rd_data_evict_way (rd_data_evict_way)
    );

    bind l2_localmem l2_localmem_chk u_chk (
        .clk               (clk),
        .rst_n             (rst_n),
        .rd_en             (rd_en),
        .wr_rst_flush      (wr_rst_flush),
        .rd_data_line      (rd_data_line),
        .rd_data_tag       (rd_data_tag),
        .rd_data_state     (rd_data_state),
        .rd_data_hprot     (rd_data_hprot),
        .rd_data_evict_way (rd_data_evict_way)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got %0h, expected %0h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic clear_strobes();
        nx_rd    = 1'b0;
        nx_wr    = 1'b0;
        nx_flush = '0;
        nx_ev_en = 1'b0;
    endtask

    // the DUT samples these values on the following rising edge
    task automatic drive_edge();
        @(posedge clk);
        set_in            <= nx_set;
        rd_en             <= nx_rd;
        wr_en             <= nx_wr;
        way               <= nx_way;
        wr_data_line      <= nx_line;
        wr_data_tag       <= nx_tag;
        wr_data_state     <= nx_state;
        wr_data_hprot     <= nx_hprot;
        wr_rst_flush      <= nx_flush;
        wr_en_evict_way   <= nx_ev_en;
        wr_data_evict_way <= nx_ev_way;
        clear_strobes();
    endtask

    task automatic malformed(input logic [7:0] op);
        $display("stimulus record '%c' has missing or bad fields", op);
        error_count++;
    endtask

    task automatic check_reset_outputs();
        int i;
        for (i = 0; i < l2_mem_pkg::num_ways; i++) begin
            check_value($sformatf("rd_data_line[%0d]", i), rd_data_line[i], '0);
            check_value($sformatf("rd_data_tag[%0d]", i), 128'(rd_data_tag[i]), '0);
            check_value($sformatf("rd_data_state[%0d]", i), 128'(rd_data_state[i]), '0);
            check_value($sformatf("rd_data_hprot[%0d]", i), 128'(rd_data_hprot[i]), '0);
        end
        check_value("rd_data_evict_way", 128'(rd_data_evict_way), '0);
    endtask

    // read strobe for one cycle, then compare one cycle later
    task automatic read_and_compare();
        l2_mem_pkg::line_t  e_line  [l2_mem_pkg::num_ways];
        l2_mem_pkg::tag_t   e_tag   [l2_mem_pkg::num_ways];
        l2_mem_pkg::state_t e_state [l2_mem_pkg::num_ways];
        l2_mem_pkg::hprot_t e_hprot [l2_mem_pkg::num_ways];
        l2_mem_pkg::way_t   e_evict;
        int fields;
        int i;
        fields = $fscanf(fd, " %h", nx_set);
        for (i = 0; i < l2_mem_pkg::num_ways; i++) begin
            fields += $fscanf(fd, " %h %h %h %h", e_line[i], e_tag[i], e_state[i], e_hprot[i]);
        end
        fields += $fscanf(fd, " %h", e_evict);
        if (fields != 18) begin
            malformed("R");
        end
        nx_rd = 1'b1;
        drive_edge();
        drive_edge();
        @(negedge clk);
        for (i = 0; i < l2_mem_pkg::num_ways; i++) begin
            check_value($sformatf("rd_data_line[%0d]", i), rd_data_line[i], e_line[i]);
            check_value($sformatf("rd_data_tag[%0d]", i), 128'(rd_data_tag[i]),
                        128'(e_tag[i]));
            check_value($sformatf("rd_data_state[%0d]", i), 128'(rd_data_state[i]),
                        128'(e_state[i]));
            check_value($sformatf("rd_data_hprot[%0d]", i), 128'(rd_data_hprot[i]),
                        128'(e_hprot[i]));
        end
        check_value("rd_data_evict_way", 128'(rd_data_evict_way), 128'(e_evict));
    endtask

    initial begin
        logic [7:0]       op;
        logic [8*256-1:0] text;
        int               code;
        int               line_count;
        int               test_num;
        int               errors_at_start;
        rst_n             = 1'b0;
        set_in            = '0;
        rd_en             = 1'b0;
        way               = '0;
        wr_en             = 1'b0;
        wr_data_line      = '0;
        wr_data_tag       = '0;
        wr_data_state     = '0;
        wr_data_hprot     = '0;
        wr_rst_flush      = '0;
        wr_en_evict_way   = 1'b0;
        wr_data_evict_way = '0;
        nx_set            = '0;
        nx_way            = '0;
        nx_line           = '0;
        nx_tag            = '0;
        nx_state          = '0;
        nx_hprot          = '0;
        nx_ev_way         = '0;
        clear_strobes();
        error_count     = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        errors_at_start = 0;
        fd = $fopen(stim_path, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", stim_path);
            error_count++;
        end else begin
            // first pass only sizes the watchdog
            line_count = 0;
            while ($fgets(text, fd) != 0) begin
                line_count++;
            end
            $fclose(fd);
            fd = $fopen(stim_path, "r");
            watchdog_cycles = line_count * cycles_per_line + reset_cycles + 8;
        end
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_reset_outputs();
        while (fd != 0 && $fscanf(fd, " %c", op) == 1) begin
            case (op)
                "#": code = $fgets(text, fd);
                "W", "w": begin
                    code = $fscanf(fd, " %h %h %h %h %h %h", nx_set, nx_way, nx_tag,
                                   nx_state, nx_hprot, nx_line);
                    if (code != 6) malformed(op);
                    nx_wr = 1'b1;
                    // lower case w shares the edge of the next record
                    if (op == "W") begin
                        drive_edge();
                        drive_edge();
                    end
                end
                "F": begin
                    code = $fscanf(fd, " %h %h %h", nx_set, nx_flush, nx_state);
                    if (code != 3) malformed(op);
                    drive_edge();
                    drive_edge();
                end
                "E": begin
                    code = $fscanf(fd, " %h %h", nx_set, nx_ev_way);
                    if (code != 2) malformed(op);
                    nx_ev_en = 1'b1;
                    drive_edge();
                    drive_edge();
                end
                "R": read_and_compare();
                "T": begin
                    code = $fscanf(fd, " %d", test_num);
                    if (error_count == errors_at_start) begin
                        $display("test %0d: PASS", test_num);
                        tests_passed++;
                    end else begin
                        $display("test %0d: FAIL with %0d errors", test_num,
                                 error_count - errors_at_start);
                        tests_failed++;
                    end
                    errors_at_start = error_count;
                end
                default: begin
                    $display("unknown operation '%c' in stimulus file", op);
                    error_count++;
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (error_count == 0 && tests_failed == 0 && tests_passed > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: stimulus did not finish within %0d cycles", watchdog_cycles);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/l2_localmem_chk.sv
`timescale 1ns/1ps
`default_nettype none

module l2_localmem_chk (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              rd_en,
    input  l2_mem_pkg::way_mask_t                             wr_rst_flush,
    input  l2_mem_pkg::line_t  [l2_mem_pkg::num_ways-1:0]     rd_data_line,
    input  l2_mem_pkg::tag_t   [l2_mem_pkg::num_ways-1:0]     rd_data_tag,
    input  l2_mem_pkg::state_t [l2_mem_pkg::num_ways-1:0]     rd_data_state,
    input  l2_mem_pkg::hprot_t [l2_mem_pkg::num_ways-1:0]     rd_data_hprot,
    input  l2_mem_pkg::way_t                                  rd_data_evict_way
);

    logic all_zero;

    assign all_zero = (rd_data_line == '0) && (rd_data_tag == '0) &&
                      (rd_data_state == '0) && (rd_data_hprot == '0) &&
                      (rd_data_evict_way == '0);

    // output registers clear on every reset edge
    a_reset_zero: assert property (@(posedge clk) !rst_n |=> all_zero)
        else $error("read outputs not zero after a reset edge");

    // without a read strobe the registered outputs hold
    a_hold_no_read: assert property (@(posedge clk) disable iff (!rst_n)
        !rd_en |=> ($stable(rd_data_line) && $stable(rd_data_tag) &&
                    $stable(rd_data_state) && $stable(rd_data_hprot) &&
                    $stable(rd_data_evict_way)))
        else $error("read outputs changed without rd_en");

    a_flush_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(wr_rst_flush))
        else $error("wr_rst_flush is unknown");

endmodule

`default_nettype wire

//--- rtl/l2_localmem.sv
`timescale 1ns/1ps
`default_nettype none

module l2_localmem (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  l2_mem_pkg::set_t                                  set_in,
    input  logic                                              rd_en,
    input  l2_mem_pkg::way_t                                  way,
    input  logic                                              wr_en,
    input  l2_mem_pkg::line_t                                 wr_data_line,
    input  l2_mem_pkg::tag_t                                  wr_data_tag,
    input  l2_mem_pkg::state_t                                wr_data_state,
    input  l2_mem_pkg::hprot_t                                wr_data_hprot,
    input  l2_mem_pkg::way_mask_t                             wr_rst_flush,
    input  logic                                              wr_en_evict_way,
    input  l2_mem_pkg::way_t                                  wr_data_evict_way,
    output l2_mem_pkg::line_t  [l2_mem_pkg::num_ways-1:0]     rd_data_line,
    output l2_mem_pkg::tag_t   [l2_mem_pkg::num_ways-1:0]     rd_data_tag,
    output l2_mem_pkg::state_t [l2_mem_pkg::num_ways-1:0]     rd_data_state,
    output l2_mem_pkg::hprot_t [l2_mem_pkg::num_ways-1:0]     rd_data_hprot,
    output l2_mem_pkg::way_t                                  rd_data_evict_way
);

    l2_wr_if u_wr ();

    // gather the top-level strobes and write data for the stores
    assign u_wr.set          = set_in;
    assign u_wr.rd_en        = rd_en;
    assign u_wr.wr_en        = wr_en;
    assign u_wr.way          = way;
    assign u_wr.wr_line      = wr_data_line;
    assign u_wr.wr_tag       = wr_data_tag;
    assign u_wr.wr_state     = wr_data_state;
    assign u_wr.wr_hprot     = wr_data_hprot;
    assign u_wr.flush        = wr_rst_flush;
    assign u_wr.wr_en_evict  = wr_en_evict_way;
    assign u_wr.wr_evict_way = wr_data_evict_way;

    // one store per way, each decodes its own write enables
    genvar g;
    generate
        for (g = 0; g < l2_mem_pkg::num_ways; g++) begin : g_way
            l2_way_store #(
                .way_id (g)
            ) u_way_store (
                .clk      (clk),
                .rst_n    (rst_n),
                .wr       (u_wr.way_side),
                .rd_line  (rd_data_line[g]),
                .rd_tag   (rd_data_tag[g]),
                .rd_state (rd_data_state[g]),
                .rd_hprot (rd_data_hprot[g])
            );
        end
    endgenerate

    // evict way is kept per set, not per way
    l2_evict_store u_evict_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr           (u_wr.evict_side),
        .rd_evict_way (rd_data_evict_way)
    );

endmodule

`default_nettype wire

//--- rtl/l2_evict_store.sv
`timescale 1ns/1ps
`default_nettype none

module l2_evict_store (
    input  logic              clk,
    input  logic              rst_n,
    l2_wr_if.evict_side       wr,
    output l2_mem_pkg::way_t  rd_evict_way
);

    // next way to evict, one entry per set
    l2_mem_pkg::way_t evict_mem [l2_mem_pkg::num_sets];

    // updated by the replacement logic, independent of the way writes
    always_ff @(posedge clk) begin
        if (wr.wr_en_evict) begin
            evict_mem[wr.set] <= wr.wr_evict_way;
        end
    end

    // registered read, holds until the next rd_en
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_evict_way <= '0;
        end else if (wr.rd_en) begin
            rd_evict_way <= evict_mem[wr.set];
        end
    end

endmodule

`default_nettype wire

//--- rtl/l2_way_store.sv
`timescale 1ns/1ps
`default_nettype none

module l2_way_store #(
    parameter int way_id = 0
) (
    input  logic                clk,
    input  logic                rst_n,
    l2_wr_if.way_side           wr,
    output l2_mem_pkg::line_t   rd_line,
    output l2_mem_pkg::tag_t    rd_tag,
    output l2_mem_pkg::state_t  rd_state,
    output l2_mem_pkg::hprot_t  rd_hprot
);

    // one entry per set for each field of this way
    l2_mem_pkg::line_t  line_mem  [l2_mem_pkg::num_sets];
    l2_mem_pkg::tag_t   tag_mem   [l2_mem_pkg::num_sets];
    l2_mem_pkg::state_t state_mem [l2_mem_pkg::num_sets];
    l2_mem_pkg::hprot_t hprot_mem [l2_mem_pkg::num_sets];

    logic way_hit;
    logic flush_hit;
    logic full_we;
    logic state_we;

    // this way is addressed by the write
    assign way_hit = (wr.way == l2_mem_pkg::way_t'(way_id));

    // flush bit for this way
    assign flush_hit = wr.flush[way_id];

    // line, tag and hprot only follow the addressed write
    assign full_we = wr.wr_en && way_hit;

    // state is also written by a flush, with the same write state
    assign state_we = full_we || flush_hit;

    always_ff @(posedge clk) begin
        if (full_we) begin
            line_mem[wr.set] <= wr.wr_line;
        end
    end

    always_ff @(posedge clk) begin
        if (full_we) begin
            tag_mem[wr.set] <= wr.wr_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (full_we) begin
            hprot_mem[wr.set] <= wr.wr_hprot;
        end
    end

    always_ff @(posedge clk) begin
        if (state_we) begin
            state_mem[wr.set] <= wr.wr_state;
        end
    end

    // read-first: the registers take the contents from before a same-edge write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_line  <= '0;
            rd_tag   <= '0;
            rd_state <= '0;
            rd_hprot <= '0;
        end else if (wr.rd_en) begin
            rd_line  <= line_mem[wr.set];
            rd_tag   <= tag_mem[wr.set];
            rd_state <= state_mem[wr.set];
            rd_hprot <= hprot_mem[wr.set];
        end
    end

endmodule

`default_nettype wire

//--- rtl/l2_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

interface l2_wr_if;

    // addressing shared by reads and writes
    l2_mem_pkg::set_t      set;
    logic                  rd_en;

    // full write into one addressed way
    logic                  wr_en;
    l2_mem_pkg::way_t      way;
    l2_mem_pkg::line_t     wr_line;
    l2_mem_pkg::tag_t      wr_tag;
    l2_mem_pkg::state_t    wr_state;
    l2_mem_pkg::hprot_t    wr_hprot;

    // state-only write into every flagged way
    l2_mem_pkg::way_mask_t flush;

    // evict way update for the set
    logic                  wr_en_evict;
    l2_mem_pkg::way_t      wr_evict_way;

    modport way_side (
        input set, rd_en, wr_en, way, wr_line, wr_tag, wr_state, wr_hprot, flush
    );

    modport evict_side (
        input set, rd_en, wr_en_evict, wr_evict_way
    );

endinterface

`default_nettype wire

//--- rtl/l2_mem_pkg.sv
`default_nettype none

package l2_mem_pkg;

    // cache geometry
    localparam int num_ways   = 4;
    localparam int set_bits   = 6;
    localparam int way_bits   = 2;
    localparam int tag_bits   = 20;
    localparam int state_bits = 3;
    localparam int line_bits  = 128;

    // depth of every set-indexed array
    localparam int num_sets = 1 << set_bits;

    // set index and way index
    typedef logic [set_bits-1:0] set_t;
    typedef logic [way_bits-1:0] way_t;

    // per-way fields held for each set
    typedef logic [tag_bits-1:0]   tag_t;
    typedef logic [state_bits-1:0] state_t;
    typedef logic                  hprot_t;
    typedef logic [line_bits-1:0]  line_t;

    // one flush bit per way, bit i selects way i
    typedef logic [num_ways-1:0] way_mask_t;

endpackage

`default_nettype wire
